// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input  wire logic                i_clk,
	input  wire logic                i_ren,
	input  wire icache_pkg::index_t  i_rindex,
	input  wire icache_pkg::offset_t i_roffset,
	output icache_pkg::word_t        o_rdata,
	input  wire logic                i_wen,
	input  wire icache_pkg::index_t  i_windex,
	input  wire icache_pkg::offset_t i_woffset,
	input  wire icache_pkg::word_t   i_wdata
);

	// one word per {index, offset}
	icache_pkg::word_t r_mem [icache_pkg::SETS * icache_pkg::WORD_PER_LINE];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			r_mem[{i_windex, i_woffset}] <= i_wdata;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ren) begin
			o_rdata <= r_mem[{i_rindex, i_roffset}];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// 16 KiB, 4 ways, 32 byte lines
	localparam int WORD_PER_LINE = 8;
	localparam int WAYS = 4;
	localparam int SETS = 128;
	localparam int OFFSET_W = 3;
	localparam int INDEX_W = 7;
	localparam int TAG_W = 20;
	localparam int WAY_W = 2;
	localparam int PLRU_W = 3;

	typedef logic [31:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [PLRU_W-1:0] plru_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		logic valid;
		word_t addr; // word aligned, critical word first
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic last;
		word_t data;
	} mem_resp_t;

	typedef enum logic [1:0] {
		INVALIDATING,
		IDLE,
		RECEIVING
	} cache_state_t;

	function automatic index_t addr_index(input word_t addr);
		return addr[2 + OFFSET_W +: INDEX_W];
	endfunction

	function automatic tag_t addr_tag(input word_t addr);
		return addr[31 -: TAG_W];
	endfunction

	function automatic offset_t addr_offset(input word_t addr);
		return addr[2 +: OFFSET_W];
	endfunction

endpackage

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	input  wire logic                  i_req_valid,
	input  wire icache_pkg::word_t     i_va,
	input  wire icache_pkg::word_t     i_pa,
	output logic                       o_stall,
	output logic                       o_valid,
	output icache_pkg::word_t          o_data,
	output icache_pkg::mem_req_t       o_mem_req,
	input  wire icache_pkg::mem_resp_t i_mem_resp
);

	logic r_s2_valid;
	icache_pkg::word_t r_s2_va;

	icache_pkg::tag_entry_t w_tag_rd [icache_pkg::WAYS];
	icache_pkg::word_t w_data_rd [icache_pkg::WAYS];
	logic [icache_pkg::WAYS-1:0] w_way_hit;
	icache_pkg::way_t w_hit_way;
	logic w_any_hit;
	logic w_hit_ret;
	logic w_miss_start;
	icache_pkg::way_t w_victim;

	logic w_busy;
	logic w_tag_wen;
	logic [icache_pkg::WAYS-1:0] w_tag_way_mask;
	icache_pkg::index_t w_tag_index;
	icache_pkg::tag_entry_t w_tag_entry;
	logic w_fill_wen;
	icache_pkg::way_t w_fill_way;
	icache_pkg::index_t w_fill_index;
	icache_pkg::offset_t w_fill_offset;
	icache_pkg::word_t w_fill_data;
	logic w_fwd_valid;
	icache_pkg::word_t w_fwd_data;

	// stage 1 reads with the virtual index
	for (genvar i = 0; i < icache_pkg::WAYS; i++) begin : g_way
		tag_ram tag_ram_i (
			.i_clk    (i_clk),
			.i_ren    (!o_stall),
			.i_raddr  (icache_pkg::addr_index(i_va)),
			.o_rentry (w_tag_rd[i]),
			.i_wen    (w_tag_wen && w_tag_way_mask[i]),
			.i_waddr  (w_tag_index),
			.i_wentry (w_tag_entry)
		);

		data_ram data_ram_i (
			.i_clk     (i_clk),
			.i_ren     (!o_stall),
			.i_rindex  (icache_pkg::addr_index(i_va)),
			.i_roffset (icache_pkg::addr_offset(i_va)),
			.o_rdata   (w_data_rd[i]),
			.i_wen     (w_fill_wen && (w_fill_way == icache_pkg::way_t'(i))),
			.i_windex  (w_fill_index),
			.i_woffset (w_fill_offset),
			.i_wdata   (w_fill_data)
		);

		assign w_way_hit[i] = w_tag_rd[i].valid &&
			(w_tag_rd[i].tag == icache_pkg::addr_tag(i_pa));
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_s2_valid <= 1'b0;
		end else if (!o_stall) begin
			r_s2_valid <= i_req_valid;
		end else if (w_fwd_valid) begin
			r_s2_valid <= 1'b0; // retired by the forward
		end
	end

	always_ff @(posedge i_clk) begin
		if (!o_stall) begin
			r_s2_va <= i_va;
		end
	end

	always_comb begin
		w_hit_way = '0;
		for (int i = 0; i < icache_pkg::WAYS; i++) begin
			if (w_way_hit[i]) begin
				w_hit_way = icache_pkg::way_t'(i);
			end
		end
	end

	assign w_any_hit = |w_way_hit;
	assign w_hit_ret = r_s2_valid && w_any_hit && !w_busy;
	assign w_miss_start = r_s2_valid && !w_any_hit && !w_busy;
	assign o_stall = w_busy || (r_s2_valid && !w_any_hit);
	assign o_valid = w_hit_ret || w_fwd_valid;
	assign o_data = w_fwd_valid ? w_fwd_data : w_data_rd[w_hit_way];

	plru_tree plru_tree_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_index   (icache_pkg::addr_index(r_s2_va)),
		.i_hit     (w_hit_ret),
		.i_hit_way (w_hit_way),
		.i_miss    (w_miss_start),
		.o_victim  (w_victim)
	);

	refill_ctrl refill_ctrl_i (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_miss_start   (w_miss_start),
		.i_miss_pa      (i_pa),
		.i_victim       (w_victim),
		.i_mem_resp     (i_mem_resp),
		.o_mem_req      (o_mem_req),
		.o_busy         (w_busy),
		.o_tag_wen      (w_tag_wen),
		.o_tag_way_mask (w_tag_way_mask),
		.o_tag_index    (w_tag_index),
		.o_tag_entry    (w_tag_entry),
		.o_fill_wen     (w_fill_wen),
		.o_fill_way     (w_fill_way),
		.o_fill_index   (w_fill_index),
		.o_fill_offset  (w_fill_offset),
		.o_fill_data    (w_fill_data),
		.o_fwd_valid    (w_fwd_valid),
		.o_fwd_data     (w_fwd_data)
	);

	// a line lives in one way only
	a_onehot_hit: assert property (@(posedge i_clk) disable iff (i_rst)
		r_s2_valid |-> $onehot0(w_way_hit))
		else $error("icache_top: more than one way hit");

endmodule

`default_nettype wire

// ==== hdl/plru_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
	input  wire logic               i_clk,
	input  wire logic               i_rst,
	input  wire icache_pkg::index_t i_index,
	input  wire logic               i_hit,
	input  wire icache_pkg::way_t   i_hit_way,
	input  wire logic               i_miss,
	output icache_pkg::way_t        o_victim
);

	// bit 0 picks the half, bit 1 the left pair, bit 2 the right pair
	icache_pkg::plru_t r_plru [icache_pkg::SETS];
	icache_pkg::plru_t w_cur;
	icache_pkg::plru_t w_nxt;
	icache_pkg::way_t w_used;

	assign w_cur = r_plru[i_index];
	assign o_victim = {w_cur[0], w_cur[0] ? w_cur[2] : w_cur[1]};
	assign w_used = i_hit ? i_hit_way : o_victim;

	always_comb begin
		w_nxt = w_cur;
		w_nxt[0] = ~w_used[1]; // point at the other half
		if (w_used[1]) begin
			w_nxt[2] = ~w_used[0];
		end else begin
			w_nxt[1] = ~w_used[0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < icache_pkg::SETS; i++) begin
				r_plru[i] <= '0;
			end
		end else if (i_hit || i_miss) begin
			r_plru[i_index] <= w_nxt;
		end
	end

	a_hit_miss_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_hit && i_miss))
		else $error("plru_tree: hit and miss update in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/refill_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl (
	input  wire logic                      i_clk,
	input  wire logic                      i_rst,
	input  wire logic                      i_miss_start,
	input  wire icache_pkg::word_t         i_miss_pa,
	input  wire icache_pkg::way_t          i_victim,
	input  wire icache_pkg::mem_resp_t     i_mem_resp,
	output icache_pkg::mem_req_t           o_mem_req,
	output logic                           o_busy,
	output logic                           o_tag_wen,
	output logic [icache_pkg::WAYS-1:0]    o_tag_way_mask,
	output icache_pkg::index_t             o_tag_index,
	output icache_pkg::tag_entry_t         o_tag_entry,
	output logic                           o_fill_wen,
	output icache_pkg::way_t               o_fill_way,
	output icache_pkg::index_t             o_fill_index,
	output icache_pkg::offset_t            o_fill_offset,
	output icache_pkg::word_t              o_fill_data,
	output logic                           o_fwd_valid,
	output icache_pkg::word_t              o_fwd_data
);

	icache_pkg::cache_state_t r_state;
	icache_pkg::cache_state_t w_state;
	icache_pkg::index_t r_sweep;
	logic r_req_pulse;
	icache_pkg::word_t r_pa; // miss context
	icache_pkg::way_t r_way;
	icache_pkg::offset_t r_beat;
	logic w_beat;
	logic w_last;

	assign w_beat = (r_state == icache_pkg::RECEIVING) && i_mem_resp.valid;
	assign w_last = w_beat && i_mem_resp.last;

	always_comb begin
		w_state = r_state;
		case (r_state)
			icache_pkg::INVALIDATING: begin
				if (r_sweep == icache_pkg::index_t'(icache_pkg::SETS - 1)) begin
					w_state = icache_pkg::IDLE;
				end
			end
			icache_pkg::IDLE: begin
				if (i_miss_start) begin
					w_state = icache_pkg::RECEIVING;
				end
			end
			icache_pkg::RECEIVING: begin
				if (w_last) begin
					w_state = icache_pkg::IDLE;
				end
			end
			default: w_state = icache_pkg::INVALIDATING;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= icache_pkg::INVALIDATING;
			r_sweep <= '0;
			r_req_pulse <= 1'b0;
		end else begin
			r_state <= w_state;
			r_req_pulse <= (r_state == icache_pkg::IDLE) && i_miss_start;
			if (r_state == icache_pkg::INVALIDATING) begin
				r_sweep <= r_sweep + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if ((r_state == icache_pkg::IDLE) && i_miss_start) begin
			r_pa <= {i_miss_pa[31:2], 2'b00};
			r_way <= i_victim;
			r_beat <= '0;
		end else if (w_beat) begin
			r_beat <= r_beat + 1'b1;
		end
	end

	assign o_busy = (r_state != icache_pkg::IDLE);
	assign o_mem_req.valid = r_req_pulse;
	assign o_mem_req.addr = r_pa;

	// sweep writes all ways at once, refill only the victim
	always_comb begin
		o_tag_wen = 1'b0;
		o_tag_way_mask = '0;
		o_tag_index = icache_pkg::addr_index(r_pa);
		o_tag_entry = '0;
		if (r_state == icache_pkg::INVALIDATING) begin
			o_tag_wen = 1'b1;
			o_tag_way_mask = '1;
			o_tag_index = r_sweep;
		end else if (w_last) begin
			o_tag_wen = 1'b1;
			o_tag_way_mask = icache_pkg::WAYS'(1) << r_way;
			o_tag_entry.valid = 1'b1;
			o_tag_entry.tag = icache_pkg::addr_tag(r_pa);
		end
	end

	assign o_fill_wen = w_beat;
	assign o_fill_way = r_way;
	assign o_fill_index = icache_pkg::addr_index(r_pa);
	assign o_fill_offset = icache_pkg::addr_offset(r_pa) + r_beat; // wraps in the line
	assign o_fill_data = i_mem_resp.data;

	assign o_fwd_valid = w_beat && (r_beat == '0); // critical word
	assign o_fwd_data = i_mem_resp.data;

	a_beat_in_recv: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mem_resp.valid |-> r_state == icache_pkg::RECEIVING)
		else $error("refill_ctrl: response beat outside of a refill");

	a_req_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req.valid |=> !o_mem_req.valid)
		else $error("refill_ctrl: memory request held longer than one cycle");

endmodule

`default_nettype wire

// ==== hdl/tag_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_ram (
	input  wire logic                   i_clk,
	input  wire logic                   i_ren,
	input  wire icache_pkg::index_t     i_raddr,
	output icache_pkg::tag_entry_t      o_rentry,
	input  wire logic                   i_wen,
	input  wire icache_pkg::index_t     i_waddr,
	input  wire icache_pkg::tag_entry_t i_wentry
);

	icache_pkg::tag_entry_t r_mem [icache_pkg::SETS];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			r_mem[i_waddr] <= i_wentry;
		end
	end

	// output holds while the read is off, stage 2 relies on it
	always_ff @(posedge i_clk) begin
		if (i_ren) begin
			o_rentry <= r_mem[i_raddr];
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_icache -f vlog.f -Mdir obj_dir -o tb_icache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	exit 0
fi
exit 1

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
	input  wire logic                  i_clk,
	input  wire icache_pkg::mem_req_t  i_req,
	output icache_pkg::mem_resp_t      o_resp
);

	logic [31:0] lfsr_state;
	icache_pkg::word_t req_addr;
	icache_pkg::offset_t beat_off;
	int gap;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// fixed memory content
	function automatic icache_pkg::word_t mem_word(input icache_pkg::word_t addr);
		return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
	endfunction

	initial begin
		lfsr_state = 32'h1146;
		o_resp = '0;
		forever begin
			@(posedge i_clk);
			if (i_req.valid === 1'b1) begin
				req_addr = i_req.addr;
				beat_off = icache_pkg::addr_offset(i_req.addr); // critical word first
				for (int k = 0; k < icache_pkg::WORD_PER_LINE; k++) begin
					gap = (k == 0) ? int'(take_bits(2)) : int'(take_bits(1));
					repeat (gap) begin
						@(negedge i_clk);
						o_resp = '0;
					end
					@(negedge i_clk);
					o_resp.valid = 1'b1;
					o_resp.last = (k == icache_pkg::WORD_PER_LINE - 1);
					o_resp.data = mem_word({req_addr[31:5], beat_off, 2'b00});
					beat_off = beat_off + 1'b1; // wraps inside the line
				end
				@(negedge i_clk);
				o_resp = '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

	localparam int N_DIRECTED = 15;
	localparam int N_RANDOM = 150;
	localparam int LIMIT_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + icache_pkg::SETS + 2 + 16;

	logic clk;
	logic rst;
	logic req_valid;
	icache_pkg::word_t va;
	icache_pkg::word_t pa;
	logic stall;
	logic valid;
	icache_pkg::word_t data;
	icache_pkg::mem_req_t mem_req;
	icache_pkg::mem_resp_t mem_resp;

	logic [31:0] lfsr_state;
	logic expect_hit; // requests sent now must hit
	logic sweep_done;
	int sweep_cycles;
	logic burst_active;
	logic wait_first;
	int errors;
	int acc_count;
	int valid_count;
	int mreq_count;
	icache_pkg::word_t pend_q [$]; // accepted but not yet answered

	icache_top icache_top_i (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_req_valid (req_valid),
		.i_va        (va),
		.i_pa        (pa),
		.o_stall     (stall),
		.o_valid     (valid),
		.o_data      (data),
		.o_mem_req   (mem_req),
		.i_mem_resp  (mem_resp)
	);

	mem_model mem_model_i (
		.i_clk  (clk),
		.i_req  (mem_req),
		.o_resp (mem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic icache_pkg::word_t mem_word(input icache_pkg::word_t addr);
		return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
	endfunction

	// all land in set 0x1a with a new tag per k
	function automatic icache_pkg::word_t conflict_addr(input int k);
		return 32'h0004_0340 + (icache_pkg::word_t'(k) << 12) + (icache_pkg::word_t'(k) << 2);
	endfunction

	function automatic icache_pkg::word_t rand_addr();
		icache_pkg::word_t a;
		a = 32'h0008_0000;
		a[14:12] = 3'(take_bits(3)); // 8 tags
		a[6:5] = 2'(take_bits(2));   // 4 sets
		a[4:2] = 3'(take_bits(3));
		return a;
	endfunction

	// present one request and return once it sits in stage 2
	task automatic send(input icache_pkg::word_t addr);
		int n;
		n = acc_count;
		req_valid = 1'b1;
		va = addr;
		do @(negedge clk); while (acc_count == n);
		pa = addr;
	endtask

	task automatic idle(input int n);
		req_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic drain();
		while (valid_count != acc_count || stall) @(negedge clk);
	endtask

	task automatic hit_once(input icache_pkg::word_t addr);
		expect_hit = 1'b1;
		send(addr);
		idle(1);
		drain();
		expect_hit = 1'b0;
	endtask

	task automatic check_mem_reqs(input int since, input int expected);
		assert (mreq_count - since == expected) else begin
			errors++;
			$display("[FAIL] o_mem_req.valid pulses: expected %h, got %h",
				expected, mreq_count - since);
		end
	endtask

	always @(posedge clk) begin
		icache_pkg::word_t exp_addr;
		if (rst) begin
			sweep_done <= 1'b0;
			sweep_cycles <= 0;
			burst_active <= 1'b0;
			wait_first <= 1'b0;
		end else begin
			if (!sweep_done) begin
				if (stall) begin
					sweep_cycles <= sweep_cycles + 1;
				end else begin
					sweep_done <= 1'b1;
				end
			end
			if (valid) begin
				if (pend_q.size() == 0) begin
					errors++;
					$display("o_valid came with no request outstanding at %0t", $time);
				end else begin
					exp_addr = pend_q.pop_front();
					valid_count++;
					assert (data == mem_word(exp_addr)) else begin
						errors++;
						$display("[FAIL] o_data at %h: expected %h, got %h",
							exp_addr, mem_word(exp_addr), data);
					end
				end
			end
			if (req_valid && !stall) begin
				pend_q.push_back(va);
				acc_count++;
			end
			if (mem_resp.valid) begin
				wait_first <= 1'b0;
				if (mem_resp.last) begin
					burst_active <= 1'b0;
				end
			end
			if (mem_req.valid) begin
				mreq_count++;
				burst_active <= 1'b1;
				wait_first <= 1'b1;
				if (pend_q.size() == 0) begin
					errors++;
					$display("memory request issued with no request outstanding");
				end else begin
					assert (mem_req.addr == {pend_q[0][31:2], 2'b00}) else begin
						errors++;
						$display("[FAIL] o_mem_req.addr: expected %h, got %h",
							{pend_q[0][31:2], 2'b00}, mem_req.addr);
					end
				end
			end
		end
	end

	a_sweep_quiet: assert property (@(posedge clk) disable iff (rst)
		!sweep_done |-> !valid && !mem_req.valid)
		else begin
			errors++;
			$display("cache output active during the reset sweep");
		end

	a_sweep_not_early: assert property (@(posedge clk) disable iff (rst)
		!sweep_done && !stall |-> sweep_cycles >= icache_pkg::SETS)
		else begin
			errors++;
			$display("stall dropped before the sweep covered every set");
		end

	a_sweep_bounded: assert property (@(posedge clk) disable iff (rst)
		!sweep_done |-> sweep_cycles <= icache_pkg::SETS + 2)
		else begin
			errors++;
			$display("stall still high after the sweep should have ended");
		end

	a_single_burst: assert property (@(posedge clk) disable iff (rst)
		mem_req.valid |-> !burst_active)
		else begin
			errors++;
			$display("second memory request while a burst is still running");
		end

	a_fwd_first_beat: assert property (@(posedge clk) disable iff (rst)
		mem_resp.valid && wait_first |-> valid)
		else begin
			errors++;
			$display("first beat of a burst was not forwarded in its cycle");
		end

	a_hit_next_cycle: assert property (@(posedge clk) disable iff (rst)
		expect_hit && req_valid && !stall |=> valid)
		else begin
			errors++;
			$display("expected hit gave no result in the cycle after acceptance");
		end

	a_hit_no_fetch: assert property (@(posedge clk) disable iff (rst)
		expect_hit |-> !mem_req.valid)
		else begin
			errors++;
			$display("memory request issued for a request that should hit");
		end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int since;
		lfsr_state = 32'h1146;
		errors = 0;
		acc_count = 0;
		valid_count = 0;
		mreq_count = 0;
		rst = 1'b1;
		req_valid = 1'b0;
		va = '0;
		pa = '0;
		expect_hit = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// cold miss on offset 5 presented during the sweep
		since = mreq_count;
		send(32'h0000_1234);
		idle(1);
		drain();
		check_mem_reqs(since, 1);

		// rest of the line back to back
		since = mreq_count;
		expect_hit = 1'b1;
		for (int w = 0; w < icache_pkg::WORD_PER_LINE; w++) begin
			if (w != 5) begin
				send(32'h0000_1220 + icache_pkg::word_t'(w * 4));
			end
		end
		idle(1);
		drain();
		expect_hit = 1'b0;
		check_mem_reqs(since, 0);

		// fill set 0x1a and touch tag 0 before a fifth tag
		for (int k = 0; k < icache_pkg::WAYS; k++) begin
			send(conflict_addr(k));
		end
		idle(1);
		drain();
		hit_once(conflict_addr(0));
		send(conflict_addr(4));
		idle(1);
		drain();
		hit_once(conflict_addr(0)); // must survive the eviction

		for (int n = 0; n < N_RANDOM; n++) begin
			send(rand_addr());
			if (take_bits(2) == 0) begin
				idle(1);
			end
		end
		idle(1);
		drain();

		assert (valid_count == acc_count) else begin
			errors++;
			$display("[FAIL] o_valid pulses: expected %h, got %h", acc_count, valid_count);
		end

		$display("errors %0d, accepted %0d, results %0d, memory requests %0d",
			errors, acc_count, valid_count, mreq_count);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/icache_pkg.sv
hdl/tag_ram.sv
hdl/data_ram.sv
hdl/plru_tree.sv
hdl/refill_ctrl.sv
hdl/icache_top.sv
sim/mem_model.sv
sim/tb_icache.sv
